/* tb/keypad_stimulus.txt */
# row col hold release letter word
# letter is the pending letter after the line, word the word shown with word_valid, - for none
0 1 24 8 A -
0 1 24 8 B -
0 1 24 8 C -
0 1 24 8 A -
2 0 24 8 P -
2 0 24 8 Q -
2 0 24 8 R -
2 0 24 8 S -
0 0 24 8 S -
3 0 24 8 - -
0 2 24 8 D -
3 0 24 8 - -
2 1 24 8 T -
3 0 24 8 - -
2 2 24 8 W -
3 0 24 8 - -
1 0 24 8 G -
3 0 24 8 - -
3 2 24 8 - SDTW
1 1 24 8 J -
3 0 24 8 - -
3 1 24 8 - -
0 1 24 8 A -
3 0 24 8 - -
2 3 24 8 - -

/* all.f */
common/keypad_pkg.sv
logic/clock_divider.sv
keypad/keypad_scanner.sv
keypad/multitap_fsm.sv
logic/word_buffer.sv
logic/seg_letter_decoder.sv
logic/keypad_entry_top.sv
tb/keypad_entry_tb.sv

/* tb/keypad_entry_tb.sv */
module keypad_entry_tb;

  localparam int DIV_MAX = 3;
  localparam int MARGIN  = 200; // Spare cycles on top of the file's length

  logic                     clk;
  logic                     nRst;
  logic [3:0]               row;
  logic [3:0]               scan_col;
  keypad_pkg::ascii_t       letter;
  logic                     letter_ready;
  keypad_pkg::word_t        word;
  logic                     word_valid;
  logic                     game_end;
  logic [3:0][6:0]          seg;

  // Stimulus lines from the data file
  int          q_row[$];
  int          q_col[$];
  int          q_hold[$];
  int          q_rel[$];
  logic [7:0]  q_letter[$];
  logic [31:0] q_word[$];

  int   errors;
  int   line_errors;
  int   tests;
  int   cycles;
  int   limit;
  logic loaded;
  logic file_ok;

  // Reference model of the entry chain
  int          m_digit; // Last letter key, 2 to 9
  int          m_tap;
  logic        m_pending;
  logic [7:0]  m_letter;
  logic [31:0] m_word;
  int          m_count;
  logic        m_ready;
  logic        m_valid;
  logic        m_end;
  logic [31:0] m_sub_word;

  // Pulses seen during one line
  logic        saw_ready;
  logic        saw_valid;
  logic        saw_end;
  logic [31:0] got_sub_word;

  keypad_entry_top #(.DIV_MAX(DIV_MAX)) dut_i (
    .clk          (clk),
    .nRst         (nRst),
    .row          (row),
    .scan_col     (scan_col),
    .letter       (letter),
    .letter_ready (letter_ready),
    .word         (word),
    .word_valid   (word_valid),
    .game_end     (game_end),
    .seg          (seg)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog
  initial begin
    cycles = 0;
    wait (loaded);
    while (cycles <= limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("TB FAILED");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
      line_errors++;
    end
  endtask

  function automatic logic [7:0] group_base(input int d);
    case (d)
      2: group_base = "A";
      3: group_base = "D";
      4: group_base = "G";
      5: group_base = "J";
      6: group_base = "M";
      7: group_base = "P";
      8: group_base = "T";
      default: group_base = "W";
    endcase
  endfunction

  task automatic blank_model();
    m_word    = {4{keypad_pkg::BLANK_CHAR}};
    m_count   = 0;
    m_pending = 1'b0;
    m_letter  = keypad_pkg::BLANK_CHAR;
  endtask

  // Expected effect of one key press
  task automatic model_press(input int r, input int c);
    int d;
    m_ready = 1'b0;
    m_valid = 1'b0;
    m_end   = 1'b0;
    d = (r < 3 && c < 3) ? 3 * r + c + 1 : 0; // Phone digit, 1 is no letter key
    if (d >= 2) begin
      if (m_pending && d == m_digit) begin
        m_tap = (m_tap + 1) % ((d == 7 || d == 9) ? 4 : 3);
      end else begin
        m_tap = 0;
      end
      m_digit   = d;
      m_pending = 1'b1;
      m_letter  = group_base(d) + 8'(m_tap);
    end else if (r == 3 && c == 0 && m_pending) begin
      m_ready = 1'b1;
      if (m_count < 4) begin
        m_word = {m_word[23:0], m_letter}; // Newest letter in slot 0
        m_count++;
      end
      m_pending = 1'b0;
      m_letter  = keypad_pkg::BLANK_CHAR;
    end else if (r == 3 && c == 2) begin
      m_valid    = 1'b1;
      m_sub_word = m_word;
      blank_model();
    end else if ((r == 3 && c == 1) || (r == 2 && c == 3)) begin
      m_end = (r == 2); // Game end, else clear
      blank_model();
    end
  endtask

  task automatic check_seg();
    for (int s = 0; s < 4; s++) begin
      if (m_word[8*s +: 8] == keypad_pkg::BLANK_CHAR) begin
        check_value($sformatf("seg[%0d]", s), seg[s], 7'b0001000); // Segment d only
      end else begin
        check_value($sformatf("seg[%0d] lit", s),
                    seg[s] != 7'b0001000 && seg[s] != 7'b0000000, 1'b1);
      end
    end
  endtask

  task automatic load_stimulus(output logic ok);
    int          fd;
    int          n;
    int          r;
    int          c;
    int          h;
    int          rl;
    int          total;
    string       line;
    logic [7:0]  let_s;
    logic [31:0] word_s;
    total = 0;
    fd = $fopen("tb/keypad_stimulus.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%d %d %d %d %s %s", r, c, h, rl, let_s, word_s);
          if (n == 6) begin
            q_row.push_back(r);
            q_col.push_back(c);
            q_hold.push_back(h);
            q_rel.push_back(rl);
            q_letter.push_back((let_s == "-") ? keypad_pkg::BLANK_CHAR : let_s);
            q_word.push_back(word_s);
            total += h + rl;
          end
        end
      end
      $fclose(fd);
    end
    ok     = (q_row.size() > 0);
    limit  = 4 + total + MARGIN;
    loaded = 1'b1;
  endtask

  // Press, hold and release one key, then compare
  task automatic run_line(input int i);
    int r;
    int c;
    r = q_row[i];
    c = q_col[i];
    line_errors = 0;
    saw_ready   = 1'b0;
    saw_valid   = 1'b0;
    saw_end     = 1'b0;
    model_press(r, c);
    for (int k = 0; k < q_hold[i] + q_rel[i]; k++) begin
      @(negedge clk);
      if (letter_ready) saw_ready = 1'b1;
      if (game_end) saw_end = 1'b1;
      if (word_valid) begin
        saw_valid    = 1'b1;
        got_sub_word = word; // Word shown with the pulse
      end
      // Keypad contact, row seen only on the key's column
      if (k < q_hold[i] && scan_col[3-c] == 1'b0) begin
        row = 4'b1000 >> r;
      end else begin
        row = 4'b0000;
      end
    end
    check_value("letter (file)", q_letter[i], m_letter);
    check_value("letter", letter, q_letter[i]);
    check_value("word", word, m_word);
    check_value("letter_ready", saw_ready, m_ready);
    check_value("game_end", saw_end, m_end);
    check_value("word_valid (file)", m_valid, q_word[i] != "-");
    check_value("word_valid", saw_valid, m_valid);
    if (m_valid) begin
      check_value("submitted word (file)", q_word[i], m_sub_word);
      check_value("submitted word", got_sub_word, q_word[i]);
    end
    check_seg();
    tests++;
    $display("Test %0d key row %0d col %0d: %s", i + 1, r, c,
             (line_errors == 0) ? "ok" : "mismatch");
  endtask

  initial begin
    nRst   = 1'b0;
    row    = 4'b0000;
    errors = 0;
    tests  = 0;
    limit  = 0;
    loaded = 1'b0;
    load_stimulus(file_ok);
    if (!file_ok) begin
      $display("The stimulus file tb/keypad_stimulus.txt is missing or holds no tests");
      $display("TB FAILED");
    end else begin
      blank_model();
      m_digit = 0;
      m_tap   = 0;
      repeat (4) @(negedge clk);
      nRst        = 1'b1;
      line_errors = 0;
      // Reset values, before the first clock edge
      check_value("scan_col", scan_col, 4'b1111);
      check_value("letter_ready", letter_ready, 1'b0);
      check_value("word_valid", word_valid, 1'b0);
      check_value("game_end", game_end, 1'b0);
      check_value("letter", letter, keypad_pkg::BLANK_CHAR);
      check_value("word", word, m_word);
      check_seg();
      tests++;
      $display("Test 0 reset: %s", (line_errors == 0) ? "ok" : "mismatch");
      for (int i = 0; i < q_row.size(); i++) begin
        run_line(i);
      end
      $display("Done: %0d tests, %0d errors", tests, errors);
      if (errors == 0) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
    end
    $finish;
  end

endmodule

/* logic/keypad_entry_top.sv */
module keypad_entry_top #(
  parameter int unsigned DIV_MAX = 24999
) (
  input  logic               clk,
  input  logic               nRst,
  input  logic [3:0]         row,
  output logic [3:0]         scan_col,
  output keypad_pkg::ascii_t letter,
  output logic               letter_ready,
  output keypad_pkg::word_t  word,
  output logic               word_valid,
  output logic               game_end,
  output logic [3:0][6:0]    seg // seg[0] shows the newest letter
);

  logic                  tick;
  keypad_pkg::key_code_t key;
  logic                  press;
  logic                  word_submit;
  logic                  clear;

  clock_divider #(.DIV_MAX(DIV_MAX)) u_clock_divider (
    .clk  (clk),
    .nRst (nRst),
    .tick (tick)
  );

  keypad_scanner u_keypad_scanner (
    .clk      (clk),
    .nRst     (nRst),
    .tick     (tick),
    .row      (row),
    .scan_col (scan_col),
    .key      (key),
    .press    (press)
  );

  multitap_fsm u_multitap_fsm (
    .clk          (clk),
    .nRst         (nRst),
    .key          (key),
    .press        (press),
    .letter       (letter),
    .letter_ready (letter_ready),
    .word_submit  (word_submit),
    .clear        (clear),
    .game_end     (game_end)
  );

  word_buffer u_word_buffer (
    .clk          (clk),
    .nRst         (nRst),
    .letter       (letter),
    .letter_ready (letter_ready),
    .word_submit  (word_submit),
    .clear        (clear),
    .word         (word),
    .word_valid   (word_valid)
  );

  // One display per word slot
  for (genvar i = 0; i < 4; i++) begin : g_seg
    seg_letter_decoder u_seg_letter_decoder (
      .letter (word[8*i +: 8]),
      .glyph  (seg[i])
    );
  end

endmodule

/* logic/seg_letter_decoder.sv */
module seg_letter_decoder (
  input  keypad_pkg::ascii_t letter,
  output logic [6:0]         glyph // gfedcba, active high
);

  always_comb begin
    case (letter)
      "A": glyph = 7'b1110111;
      "B": glyph = 7'b1111100; // b
      "C": glyph = 7'b0111001;
      "D": glyph = 7'b1011110; // d
      "E": glyph = 7'b1111001;
      "F": glyph = 7'b1110001;
      "G": glyph = 7'b0111101;
      "H": glyph = 7'b1110110;
      "I": glyph = 7'b0000110;
      "J": glyph = 7'b0011110;
      "K": glyph = 7'b1110101; // Rough
      "L": glyph = 7'b0111000;
      "M": glyph = 7'b0110111; // Arch shape
      "N": glyph = 7'b1010100; // n
      "O": glyph = 7'b0111111;
      "P": glyph = 7'b1110011;
      "Q": glyph = 7'b1100111; // q
      "R": glyph = 7'b1010000; // r
      "S": glyph = 7'b1101101;
      "T": glyph = 7'b1111000; // t
      "U": glyph = 7'b0111110;
      "V": glyph = 7'b0011100; // u
      "W": glyph = 7'b0101010; // Rough
      "X": glyph = 7'b1110110; // Same as H
      "Y": glyph = 7'b1101110;
      "Z": glyph = 7'b1011011;
      keypad_pkg::BLANK_CHAR: glyph = 7'b0001000; // Segment d only
      default: glyph = 7'b0000000;
    endcase
  end

endmodule

/* logic/word_buffer.sv */
module word_buffer (
  input  logic               clk,
  input  logic               nRst,
  input  keypad_pkg::ascii_t letter,
  input  logic               letter_ready,
  input  logic               word_submit,
  input  logic               clear,
  output keypad_pkg::word_t  word,
  output logic               word_valid
);

  localparam keypad_pkg::word_t BLANK_WORD = '{default: keypad_pkg::BLANK_CHAR};
  localparam logic [2:0] WORD_LEN = 3'd4;

  logic [2:0] fill_count; // Letters held, 0 to 4

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      word       <= BLANK_WORD;
      fill_count <= 3'd0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= word_submit; // Word stays visible for this pulse
      if (clear || word_valid) begin
        word       <= BLANK_WORD; // Flush after submit, or on clear
        fill_count <= 3'd0;
      end else if (letter_ready && fill_count < WORD_LEN) begin
        // Shift older letters up, newest in slot 0
        word <= '{letter3: word.letter2,
                  letter2: word.letter1,
                  letter1: word.letter0,
                  letter0: letter};
        fill_count <= fill_count + 3'd1;
      end
      // Full word drops further letters
    end
  end

endmodule

/* keypad/multitap_fsm.sv */
module multitap_fsm (
  input  logic                  clk,
  input  logic                  nRst,
  input  keypad_pkg::key_code_t key,
  input  logic                  press,
  output keypad_pkg::ascii_t    letter, // Pending letter
  output logic                  letter_ready,
  output logic                  word_submit,
  output logic                  clear,
  output logic                  game_end
);

  keypad_pkg::tap_state_t state;
  keypad_pkg::tap_state_t next_state;
  keypad_pkg::key_code_t  prev_key; // Last letter key pressed
  keypad_pkg::key_code_t  next_prev_key;
  keypad_pkg::ascii_t     next_letter;
  logic                   next_letter_ready;
  logic                   next_word_submit;
  logic                   next_clear;
  logic                   next_game_end;
  logic                   pending;

  // First letter of each key group, blank for non-letter keys
  function automatic keypad_pkg::ascii_t base_letter(input keypad_pkg::key_code_t k);
    case (k)
      keypad_pkg::KEY_2: base_letter = "A";
      keypad_pkg::KEY_3: base_letter = "D";
      keypad_pkg::KEY_4: base_letter = "G";
      keypad_pkg::KEY_5: base_letter = "J";
      keypad_pkg::KEY_6: base_letter = "M";
      keypad_pkg::KEY_7: base_letter = "P";
      keypad_pkg::KEY_8: base_letter = "T";
      keypad_pkg::KEY_9: base_letter = "W";
      default:           base_letter = keypad_pkg::BLANK_CHAR;
    endcase
  endfunction

  // Next tap on a repeated press
  function automatic keypad_pkg::tap_state_t advance_tap(input keypad_pkg::tap_state_t s,
                                                         input keypad_pkg::key_code_t k);
    case (s)
      keypad_pkg::TAP0: advance_tap = keypad_pkg::TAP1;
      keypad_pkg::TAP1: advance_tap = keypad_pkg::TAP2;
      keypad_pkg::TAP2: begin
        // Four-letter groups on 7 and 9
        if (k == keypad_pkg::KEY_7 || k == keypad_pkg::KEY_9) begin
          advance_tap = keypad_pkg::TAP3;
        end else begin
          advance_tap = keypad_pkg::TAP0;
        end
      end
      default: advance_tap = keypad_pkg::TAP0; // Wrap from TAP3
    endcase
  endfunction

  function automatic keypad_pkg::ascii_t tap_offset(input keypad_pkg::tap_state_t s);
    case (s)
      keypad_pkg::TAP1: tap_offset = 8'd1;
      keypad_pkg::TAP2: tap_offset = 8'd2;
      keypad_pkg::TAP3: tap_offset = 8'd3;
      default:          tap_offset = 8'd0;
    endcase
  endfunction

  assign pending = (state inside {keypad_pkg::TAP0, keypad_pkg::TAP1,
                                  keypad_pkg::TAP2, keypad_pkg::TAP3});

  always_comb begin
    next_state        = state;
    next_letter       = letter;
    next_prev_key     = prev_key;
    next_letter_ready = 1'b0;
    next_word_submit  = 1'b0;
    next_clear        = 1'b0;
    next_game_end     = 1'b0;

    // Letter was handed over last cycle
    if (state == keypad_pkg::DONE) begin
      next_state  = keypad_pkg::INIT;
      next_letter = keypad_pkg::BLANK_CHAR;
    end

    if (press) begin
      if (base_letter(key) != keypad_pkg::BLANK_CHAR) begin
        if (pending && key == prev_key) begin
          next_state = advance_tap(state, key); // Same key, next letter
        end else begin
          next_state = keypad_pkg::TAP0; // New key restarts the group
        end
        next_letter   = base_letter(key) + tap_offset(next_state);
        next_prev_key = key;
      end else begin
        case (key)
          keypad_pkg::SUBMIT_LETTER_KEY: begin
            if (pending) begin
              next_state        = keypad_pkg::DONE; // Letter held one more cycle
              next_letter_ready = 1'b1;
            end
          end
          keypad_pkg::CLEAR_KEY, keypad_pkg::GAME_END_KEY: begin
            next_state    = keypad_pkg::INIT;
            next_letter   = keypad_pkg::BLANK_CHAR;
            next_clear    = 1'b1;
            next_game_end = (key == keypad_pkg::GAME_END_KEY);
          end
          keypad_pkg::SUBMIT_WORD_KEY: begin
            next_state       = keypad_pkg::INIT;
            next_letter      = keypad_pkg::BLANK_CHAR; // Pending letter discarded
            next_word_submit = 1'b1;
          end
          default: ; // Invalid key ignored
        endcase
      end
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state        <= keypad_pkg::INIT;
      prev_key     <= '0;
      letter       <= keypad_pkg::BLANK_CHAR;
      letter_ready <= 1'b0;
      word_submit  <= 1'b0;
      clear        <= 1'b0;
      game_end     <= 1'b0;
    end else begin
      state        <= next_state;
      prev_key     <= next_prev_key;
      letter       <= next_letter;
      letter_ready <= next_letter_ready;
      word_submit  <= next_word_submit;
      clear        <= next_clear;
      game_end     <= next_game_end;
    end
  end

  // One command per press
  assert property (@(posedge clk) disable iff (!nRst)
    !(letter_ready && word_submit));

  // Slot empties right after the hand-over
  assert property (@(posedge clk) disable iff (!nRst)
    letter_ready |=> (letter == keypad_pkg::BLANK_CHAR));

endmodule

/* keypad/keypad_scanner.sv */
module keypad_scanner (
  input  logic                  clk,
  input  logic                  nRst,
  input  logic                  tick,
  input  logic [3:0]            row,
  output logic [3:0]            scan_col, // Active low
  output keypad_pkg::key_code_t key,
  output logic                  press
);

  logic [3:0] row_meta; // First synchronizer stage
  logic [3:0] row_sync; // Second synchronizer stage
  logic [3:0] scan_col_next;
  logic       row_active;
  logic       row_rise;
  logic       scan_started; // Set by the first tick

  // Hold the column while a key on it is seen
  assign row_active = |(row_meta | row_sync);
  assign row_rise   = |(row_meta & ~row_sync);

  always_comb begin
    scan_col_next = scan_col;
    if (tick && !row_active) begin
      case (scan_col)
        4'b0111: scan_col_next = 4'b1011;
        4'b1011: scan_col_next = 4'b1101;
        4'b1101: scan_col_next = 4'b1110;
        default: scan_col_next = 4'b0111; // Idle or column 3, back to column 0
      endcase
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      row_meta     <= 4'b0000;
      row_sync     <= 4'b0000;
      scan_col     <= 4'b1111; // No column driven
      press        <= 1'b0;
      scan_started <= 1'b0;
    end else begin
      row_meta <= row;
      row_sync <= row_meta;
      scan_col <= scan_col_next;
      press    <= row_rise; // One-cycle strobe
      if (tick) begin
        scan_started <= 1'b1;
      end
    end
  end

  // Key code goes out in the same cycle as press
  always_ff @(posedge clk) begin
    if (row_rise) begin
      key <= {row_meta, ~scan_col};
    end
  end

  // Once scanning runs, a single column is driven low at all times
  assert property (@(posedge clk) disable iff (!nRst)
    scan_started |-> $onehot(~scan_col));

endmodule

/* logic/clock_divider.sv */
module clock_divider #(
  parameter int unsigned DIV_MAX = 24999
) (
  input  logic clk,
  input  logic nRst,
  output logic tick
);

  // At least one bit even for DIV_MAX of zero
  localparam int CW = (DIV_MAX > 0) ? $clog2(DIV_MAX + 1) : 1;

  logic [CW-1:0] count;

  assign tick = (count == CW'(DIV_MAX)); // One cycle in DIV_MAX+1

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      count <= '0;
    end else if (tick) begin
      count <= '0; // Wrap
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

/* common/keypad_pkg.sv */
package keypad_pkg;

  // Upper nibble is the row one-hot, lower nibble the column one-hot
  // Row 0 and column 0 sit on bit 3 of their nibble
  typedef logic [7:0] key_code_t;

  typedef logic [7:0] ascii_t; // ASCII character code

  // Position inside the letter group of a key
  typedef enum logic [2:0] {
    INIT, // No letter pending
    TAP0,
    TAP1,
    TAP2,
    TAP3, // Only reached on keys 7 and 9
    DONE  // Letter handed over, one cycle
  } tap_state_t;

  // letter0 holds the newest letter
  typedef struct packed {
    ascii_t letter3;
    ascii_t letter2;
    ascii_t letter1;
    ascii_t letter0;
  } word_t;

  localparam ascii_t BLANK_CHAR = 8'h5F; // Underscore, empty slot

  // Letter keys
  localparam key_code_t KEY_2 = 8'b1000_0100; // R0 C1
  localparam key_code_t KEY_3 = 8'b1000_0010; // R0 C2
  localparam key_code_t KEY_4 = 8'b0100_1000; // R1 C0
  localparam key_code_t KEY_5 = 8'b0100_0100; // R1 C1
  localparam key_code_t KEY_6 = 8'b0100_0010; // R1 C2
  localparam key_code_t KEY_7 = 8'b0010_1000; // R2 C0, four letters
  localparam key_code_t KEY_8 = 8'b0010_0100; // R2 C1
  localparam key_code_t KEY_9 = 8'b0010_0010; // R2 C2, four letters

  // Command keys
  localparam key_code_t SUBMIT_LETTER_KEY = 8'b0001_1000; // R3 C0
  localparam key_code_t CLEAR_KEY         = 8'b0001_0100; // R3 C1
  localparam key_code_t SUBMIT_WORD_KEY   = 8'b0001_0010; // R3 C2
  localparam key_code_t GAME_END_KEY      = 8'b0010_0001; // R2 C3

endpackage
